// File: Makefile
SIM  = obj_dir/Vtb_periph_subsys
SRCS = flist.f $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_periph_subsys

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir

// File: design/apb_gpio.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

// GPIO block with direction, output, input and toggle registers
// responds in the first access cycle
module apb_gpio (
    input  logic                          clk_i,
    input  logic                          rst_n,
    input  periph_bus_pkg::apb_req_t      apb_req,
    output periph_bus_pkg::apb_resp_t     apb_resp,
    input  logic [`PERIPH_DATA_WIDTH-1:0] gpio_in,
    output logic [`PERIPH_DATA_WIDTH-1:0] gpio_out,
    output logic [`PERIPH_DATA_WIDTH-1:0] gpio_oe
);

    localparam int unsigned OFFS_W = $clog2(`PERIPH_WIN_LENGTH);

    logic [OFFS_W-1:0]             offs;
    logic                          access;
    logic                          wr_en;
    logic                          err;
    logic [`PERIPH_DATA_WIDTH-1:0] rdata;
    logic [`PERIPH_DATA_WIDTH-1:0] dir_q;
    logic [`PERIPH_DATA_WIDTH-1:0] out_q;
    logic [`PERIPH_DATA_WIDTH-1:0] sync_q1;
    logic [`PERIPH_DATA_WIDTH-1:0] sync_q2;

    assign offs   = apb_req.paddr[OFFS_W-1:0];
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite & ~err;

    // read mux and error decode
    // the input register is read only, and the toggle register reads as zero
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offs)
            `REG_OFFS_0: rdata = dir_q;
            `REG_OFFS_1: rdata = out_q;
            `REG_OFFS_2: begin
                rdata = sync_q2;
                err   = apb_req.pwrite;
            end
            `REG_OFFS_3: rdata = '0;
            default:     err   = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            dir_q   <= '0;
            out_q   <= '0;
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            // two flops bring the pins into the clock domain
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
            if (wr_en) begin
                case (offs)
                    `REG_OFFS_0: dir_q <= apb_req.pwdata;
                    `REG_OFFS_1: out_q <= apb_req.pwdata;
                    `REG_OFFS_3: out_q <= out_q ^ apb_req.pwdata;
                    default:     out_q <= out_q;
                endcase
            end
        end
    end

    assign apb_resp.pready  = access;
    assign apb_resp.pslverr = access & err;
    assign apb_resp.prdata  = access ? rdata : '0;

    assign gpio_oe  = dir_q;
    assign gpio_out = out_q;

endmodule

// File: design/apb_soc_ctrl.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

// SoC control registers: chip identifier, two scratch words and the
// number of completers on the peripheral bus
// every access takes two access cycles
module apb_soc_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  periph_bus_pkg::apb_req_t  apb_req,
    output periph_bus_pkg::apb_resp_t apb_resp
);

    localparam int unsigned OFFS_W = $clog2(`PERIPH_WIN_LENGTH);

    periph_bus_pkg::soc_ctrl_state_e state_q;
    periph_bus_pkg::soc_ctrl_state_e state_d;

    logic [OFFS_W-1:0]             offs;
    logic                          access;
    logic                          ready;
    logic                          err;
    logic [`PERIPH_DATA_WIDTH-1:0] rdata;
    logic [`PERIPH_DATA_WIDTH-1:0] scratch0_q;
    logic [`PERIPH_DATA_WIDTH-1:0] scratch1_q;

    assign offs   = apb_req.paddr[OFFS_W-1:0];
    assign access = apb_req.psel & apb_req.penable;

    // the first access cycle only moves to SOC_WAIT, the second completes
    assign ready   = access && (state_q == periph_bus_pkg::SOC_WAIT);
    assign state_d = (state_q == periph_bus_pkg::SOC_WAIT) ? periph_bus_pkg::SOC_IDLE
                   : (access ? periph_bus_pkg::SOC_WAIT : periph_bus_pkg::SOC_IDLE);

    // identifier and slave count are read only
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offs)
            `REG_OFFS_0: begin
                rdata = `SOC_CHIP_ID;
                err   = apb_req.pwrite;
            end
            `REG_OFFS_1: rdata = scratch0_q;
            `REG_OFFS_2: rdata = scratch1_q;
            `REG_OFFS_3: begin
                rdata = `PERIPH_DATA_WIDTH'(`PERIPH_NUM_SLAVES);
                err   = apb_req.pwrite;
            end
            default:     err   = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= periph_bus_pkg::SOC_IDLE;
            scratch0_q <= '0;
            scratch1_q <= '0;
        end else begin
            state_q <= state_d;
            // writes land on the completing edge
            if (ready && apb_req.pwrite && !err) begin
                if (offs == `REG_OFFS_1) begin
                    scratch0_q <= apb_req.pwdata;
                end
                if (offs == `REG_OFFS_2) begin
                    scratch1_q <= apb_req.pwdata;
                end
            end
        end
    end

    assign apb_resp.pready  = ready;
    assign apb_resp.pslverr = ready & err;
    assign apb_resp.prdata  = ready ? rdata : '0;

endmodule

// File: design/apb_timer.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

// free-running up-counter with a compare register and a sticky match flag
// control bit 0 enables counting, bit 1 restarts the count on a match
module apb_timer (
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  periph_bus_pkg::apb_req_t  apb_req,
    output periph_bus_pkg::apb_resp_t apb_resp,
    output logic                      timer_irq
);

    localparam int unsigned OFFS_W = $clog2(`PERIPH_WIN_LENGTH);

    logic [OFFS_W-1:0]             offs;
    logic                          access;
    logic                          wr_en;
    logic                          err;
    logic [`PERIPH_DATA_WIDTH-1:0] rdata;
    logic                          en_q;
    logic                          clr_on_match_q;
    logic [`PERIPH_DATA_WIDTH-1:0] count_q;
    logic [`PERIPH_DATA_WIDTH-1:0] cmp_q;
    logic                          flag_q;
    logic                          match;

    assign offs   = apb_req.paddr[OFFS_W-1:0];
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite & ~err;

    // a stopped timer never matches, even while count equals compare
    assign match = en_q & (count_q == cmp_q);

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offs)
            `REG_OFFS_0: rdata = {{(`PERIPH_DATA_WIDTH-2){1'b0}}, clr_on_match_q, en_q};
            `REG_OFFS_1: rdata = count_q;
            `REG_OFFS_2: rdata = cmp_q;
            `REG_OFFS_3: rdata = {{(`PERIPH_DATA_WIDTH-1){1'b0}}, flag_q};
            default:     err   = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            en_q           <= 1'b0;
            clr_on_match_q <= 1'b0;
            count_q        <= '0;
            cmp_q          <= '0;
            flag_q         <= 1'b0;
        end else begin
            if (wr_en && offs == `REG_OFFS_0) begin
                en_q           <= apb_req.pwdata[0];
                clr_on_match_q <= apb_req.pwdata[1];
            end
            if (wr_en && offs == `REG_OFFS_2) begin
                cmp_q <= apb_req.pwdata;
            end

            // a bus write to count wins over the increment
            if (wr_en && offs == `REG_OFFS_1) begin
                count_q <= apb_req.pwdata;
            end else if (match && clr_on_match_q) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end

            // a new match in the same cycle as a clear keeps the flag set
            if (match) begin
                flag_q <= 1'b1;
            end else if (wr_en && offs == `REG_OFFS_3 && apb_req.pwdata[0]) begin
                flag_q <= 1'b0;
            end
        end
    end

    assign apb_resp.pready  = access;
    assign apb_resp.pslverr = access & err;
    assign apb_resp.prdata  = access ? rdata : '0;

    assign timer_irq = flag_q;

endmodule

// File: design/periph_bus_cfg.svh
`ifndef PERIPH_BUS_CFG_SVH
`define PERIPH_BUS_CFG_SVH

// bus widths
`define PERIPH_ADDR_WIDTH 32
`define PERIPH_DATA_WIDTH 32

// number of completers behind the wrapper, also readable from SoC control
`define PERIPH_NUM_SLAVES 3

// address map, every window has the same length
`define GPIO_BASE         32'h1A10_1000
`define TIMER_BASE        32'h1A10_2000
`define SOC_CTRL_BASE     32'h1A10_3000
`define PERIPH_WIN_LENGTH 32'h0000_1000

// register offsets inside a window
// they are as wide as the offset field of a 4 KiB window
`define REG_OFFS_0 12'h000
`define REG_OFFS_1 12'h004
`define REG_OFFS_2 12'h008
`define REG_OFFS_3 12'h00C

// chip identifier returned by SoC control offset 0
`define SOC_CHIP_ID 32'h0A11_B052

`endif

// File: design/periph_bus_pkg.sv
// shared bus types for the APB peripheral subsystem
// the widths come from the configuration header
`include "periph_bus_cfg.svh"

package periph_bus_pkg;

    // request from the requester side, 67 bits
    // address and write data are shared by all completers, and the wrapper
    // gates psel and penable per peripheral
    typedef struct packed {
        logic [`PERIPH_ADDR_WIDTH-1:0] paddr;
        logic [`PERIPH_DATA_WIDTH-1:0] pwdata;
        logic                          pwrite;
        logic                          psel;
        logic                          penable;
    } apb_req_t;

    // response from a completer, 34 bits
    // prdata and pslverr only carry meaning while pready is high
    typedef struct packed {
        logic [`PERIPH_DATA_WIDTH-1:0] prdata;
        logic                          pready;
        logic                          pslverr;
    } apb_resp_t;

    // result of the address decode in the bus wrapper
    // PERIPH_NONE marks an address outside every window
    typedef enum logic [1:0] {
        PERIPH_GPIO     = 2'd0,
        PERIPH_TIMER    = 2'd1,
        PERIPH_SOC_CTRL = 2'd2,
        PERIPH_NONE     = 2'd3
    } periph_idx_e;

    // access state of the SoC control block
    // SOC_WAIT is the single inserted wait state
    typedef enum logic {
        SOC_IDLE = 1'b0,
        SOC_WAIT = 1'b1
    } soc_ctrl_state_e;

endpackage

// File: design/periph_bus_wrap.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

// APB decoder and router for the peripheral subsystem
// one requester comes in, three completers go out, and addresses that hit
// no window are answered here with an error
// everything is combinational, so no clock or reset reaches this block
module periph_bus_wrap (
    input  periph_bus_pkg::apb_req_t  apb_req,
    output periph_bus_pkg::apb_resp_t apb_resp,

    output periph_bus_pkg::apb_req_t  gpio_req,
    output periph_bus_pkg::apb_req_t  timer_req,
    output periph_bus_pkg::apb_req_t  soc_ctrl_req,

    input  periph_bus_pkg::apb_resp_t gpio_resp,
    input  periph_bus_pkg::apb_resp_t timer_resp,
    input  periph_bus_pkg::apb_resp_t soc_ctrl_resp
);

    periph_bus_pkg::periph_idx_e periph_idx;
    periph_bus_pkg::apb_resp_t   err_resp;
    logic                        access;

    // true when addr falls in [base, base + window length)
    // the subtraction keeps the test free of overflow at the top of the map
    function automatic logic in_window(
        input logic [`PERIPH_ADDR_WIDTH-1:0] addr,
        input logic [`PERIPH_ADDR_WIDTH-1:0] base
    );
        logic [`PERIPH_ADDR_WIDTH-1:0] rel;
        rel = addr - base;
        return (addr >= base) && (rel < `PERIPH_WIN_LENGTH);
    endfunction

    // pass address, data and direction through, but hold psel and penable
    // low toward a completer that was not selected
    function automatic periph_bus_pkg::apb_req_t route(
        input periph_bus_pkg::apb_req_t req,
        input logic                     hit
    );
        periph_bus_pkg::apb_req_t r;
        r         = req;
        r.psel    = req.psel & hit;
        r.penable = req.penable & hit;
        return r;
    endfunction

    // the windows do not overlap, so the order of the tests does not matter
    always_comb begin
        if (in_window(apb_req.paddr, `GPIO_BASE)) begin
            periph_idx = periph_bus_pkg::PERIPH_GPIO;
        end else if (in_window(apb_req.paddr, `TIMER_BASE)) begin
            periph_idx = periph_bus_pkg::PERIPH_TIMER;
        end else if (in_window(apb_req.paddr, `SOC_CTRL_BASE)) begin
            periph_idx = periph_bus_pkg::PERIPH_SOC_CTRL;
        end else begin
            periph_idx = periph_bus_pkg::PERIPH_NONE;
        end
    end

    assign gpio_req     = route(apb_req, periph_idx == periph_bus_pkg::PERIPH_GPIO);
    assign timer_req    = route(apb_req, periph_idx == periph_bus_pkg::PERIPH_TIMER);
    assign soc_ctrl_req = route(apb_req, periph_idx == periph_bus_pkg::PERIPH_SOC_CTRL);

    // unmapped addresses complete in the first access cycle with an error
    assign access = apb_req.psel & apb_req.penable;

    always_comb begin
        err_resp.prdata  = '0;
        err_resp.pready  = access;
        err_resp.pslverr = access;
    end

    // response from the selected completer
    always_comb begin
        case (periph_idx)
            periph_bus_pkg::PERIPH_GPIO: begin
                apb_resp = gpio_resp;
            end
            periph_bus_pkg::PERIPH_TIMER: begin
                apb_resp = timer_resp;
            end
            periph_bus_pkg::PERIPH_SOC_CTRL: begin
                apb_resp = soc_ctrl_resp;
            end
            default: begin
                // PERIPH_NONE
                apb_resp = err_resp;
            end
        endcase
    end

endmodule

// File: design/periph_subsys_top.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

// APB peripheral subsystem: bus wrapper plus GPIO, timer and SoC control
module periph_subsys_top (
    input  logic                          clk_i,
    input  logic                          rst_n,
    input  periph_bus_pkg::apb_req_t      apb_req,
    output periph_bus_pkg::apb_resp_t     apb_resp,
    input  logic [`PERIPH_DATA_WIDTH-1:0] gpio_in,
    output logic [`PERIPH_DATA_WIDTH-1:0] gpio_out,
    output logic [`PERIPH_DATA_WIDTH-1:0] gpio_oe,
    output logic                          timer_irq
);

    periph_bus_pkg::apb_req_t  gpio_req;
    periph_bus_pkg::apb_req_t  timer_req;
    periph_bus_pkg::apb_req_t  soc_ctrl_req;
    periph_bus_pkg::apb_resp_t gpio_resp;
    periph_bus_pkg::apb_resp_t timer_resp;
    periph_bus_pkg::apb_resp_t soc_ctrl_resp;

    periph_bus_wrap u_bus_wrap (
        .apb_req       (apb_req),
        .apb_resp      (apb_resp),
        .gpio_req      (gpio_req),
        .timer_req     (timer_req),
        .soc_ctrl_req  (soc_ctrl_req),
        .gpio_resp     (gpio_resp),
        .timer_resp    (timer_resp),
        .soc_ctrl_resp (soc_ctrl_resp)
    );

    apb_gpio u_gpio (
        .clk_i    (clk_i),
        .rst_n    (rst_n),
        .apb_req  (gpio_req),
        .apb_resp (gpio_resp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    apb_timer u_timer (
        .clk_i     (clk_i),
        .rst_n     (rst_n),
        .apb_req   (timer_req),
        .apb_resp  (timer_resp),
        .timer_irq (timer_irq)
    );

    apb_soc_ctrl u_soc_ctrl (
        .clk_i    (clk_i),
        .rst_n    (rst_n),
        .apb_req  (soc_ctrl_req),
        .apb_resp (soc_ctrl_resp)
    );

endmodule

// File: flist.f
+incdir+design
design/periph_bus_pkg.sv
design/periph_bus_wrap.sv
design/apb_gpio.sv
design/apb_timer.sv
design/apb_soc_ctrl.sv
design/periph_subsys_top.sv
tb/tb_periph_subsys.sv

// File: tb/tb_periph_subsys.sv
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

module tb_periph_subsys;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ACCESS = 8;
    localparam int MAX_POLLS  = 60;
    // room for about 300 transfers of up to 5 cycles each plus the timer polls and some margin
    localparam int RUN_CYCLES = 300 * 5 + MAX_POLLS * 5 + 700;

    typedef struct packed {
        logic [31:0] data;
        logic        err;
    } result_t;

    logic                      clk;
    logic                      rst_n;
    periph_bus_pkg::apb_req_t  apb_req;
    periph_bus_pkg::apb_resp_t apb_resp;
    logic [31:0]               gpio_in;
    logic [31:0]               gpio_out;
    logic [31:0]               gpio_oe;
    logic                      timer_irq;

    int          errors;
    integer      seed;
    int          last_cycles;
    logic [11:0] offs_tab [4];
    logic [31:0] rand_addrs [6];

    // shadow copies of the registers that the testbench can predict
    logic [31:0] sh_dir;
    logic [31:0] sh_out;
    logic [31:0] sh_in;
    logic [31:0] sh_scr0;
    logic [31:0] sh_scr1;
    logic [31:0] sh_cmp;
    logic [1:0]  sh_ctrl;

    event    read_done;
    string   chk_name;
    result_t chk_exp;
    result_t chk_got;

    periph_subsys_top DUT (
        .clk_i     (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_resp  (apb_resp),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .timer_irq (timer_irq)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected read response from the address map and the shadow registers
    // count and status are expected as zero since they are only read while the timer is idle
    function automatic result_t ref_read(input logic [31:0] addr);
        result_t     r;
        logic [11:0] offs;
        logic [31:0] base;
        offs = 12'(addr % `PERIPH_WIN_LENGTH);
        base = addr - {20'b0, offs};
        r = '{data: '0, err: 1'b1};
        if (base == `GPIO_BASE) begin
            case (offs)
                `REG_OFFS_0: r = '{data: sh_dir, err: 1'b0};
                `REG_OFFS_1: r = '{data: sh_out, err: 1'b0};
                `REG_OFFS_2: r = '{data: sh_in, err: 1'b0};
                `REG_OFFS_3: r = '{data: '0, err: 1'b0};
                default:     r.err = 1'b1;
            endcase
        end else if (base == `TIMER_BASE) begin
            case (offs)
                `REG_OFFS_0: r = '{data: {30'b0, sh_ctrl}, err: 1'b0};
                `REG_OFFS_2: r = '{data: sh_cmp, err: 1'b0};
                `REG_OFFS_1, `REG_OFFS_3: r = '{data: '0, err: 1'b0};
                default:     r.err = 1'b1;
            endcase
        end else if (base == `SOC_CTRL_BASE) begin
            case (offs)
                `REG_OFFS_0: r = '{data: `SOC_CHIP_ID, err: 1'b0};
                `REG_OFFS_1: r = '{data: sh_scr0, err: 1'b0};
                `REG_OFFS_2: r = '{data: sh_scr1, err: 1'b0};
                `REG_OFFS_3: r = '{data: 32'(`PERIPH_NUM_SLAVES), err: 1'b0};
                default:     r.err = 1'b1;
            endcase
        end
        return r;
    endfunction

    // updates the shadow registers and returns the expected pslverr of a write
    function automatic logic ref_write(input logic [31:0] addr, input logic [31:0] data);
        logic [11:0] offs;
        logic [31:0] base;
        offs = 12'(addr % `PERIPH_WIN_LENGTH);
        base = addr - {20'b0, offs};
        if (base == `GPIO_BASE) begin
            case (offs)
                `REG_OFFS_0: sh_dir = data;
                `REG_OFFS_1: sh_out = data;
                `REG_OFFS_3: sh_out = sh_out ^ data;
                default:     return 1'b1;
            endcase
            return 1'b0;
        end else if (base == `TIMER_BASE) begin
            case (offs)
                `REG_OFFS_0: sh_ctrl = data[1:0];
                `REG_OFFS_2: sh_cmp = data;
                `REG_OFFS_1, `REG_OFFS_3: begin
                end
                default:     return 1'b1;
            endcase
            return 1'b0;
        end else if (base == `SOC_CTRL_BASE) begin
            case (offs)
                `REG_OFFS_1: sh_scr0 = data;
                `REG_OFFS_2: sh_scr1 = data;
                default:     return 1'b1;
            endcase
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // one APB transfer with the response sampled at the falling edge
    task automatic apb_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, output result_t got);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        got    = '0;
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        apb_req.pwrite  <= write;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        // no completer may answer during the setup phase
        @(negedge clk);
        if (apb_resp.pready !== 1'b0) begin
            errors++;
            $display("Error at %0t ns: pready (setup 0x%08h) expected 0, actual %b",
                     $time, addr, apb_resp.pready);
        end
        @(posedge clk);
        apb_req.penable <= 1'b1;
        while (!done && cycles < MAX_ACCESS) begin
            @(negedge clk);
            cycles++;
            if (apb_resp.pready) begin
                got  = '{data: apb_resp.prdata, err: apb_resp.pslverr};
                done = 1'b1;
            end
        end
        if (!done) begin
            errors++;
            $display("transfer to 0x%08h got no pready within %0d cycles", addr, MAX_ACCESS);
        end
        // the transfer completes on this edge
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        last_cycles = cycles;
    endtask

    task automatic apb_read(input logic [31:0] addr, output result_t got);
        apb_transfer(addr, 1'b0, '0, got);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        result_t got;
        logic    err_exp;
        err_exp = ref_write(addr, data);
        apb_transfer(addr, 1'b1, data, got);
        if (got.err !== err_exp) begin
            errors++;
            $display("Error at %0t ns: pslverr (write 0x%08h) expected %0b, actual %0b",
                     $time, addr, err_exp, got.err);
        end
    endtask

    task automatic post_check(input string name, input result_t exp, input result_t got);
        chk_name = name;
        chk_exp  = exp;
        chk_got  = got;
        -> read_done;
    endtask

    task automatic read_check(input logic [31:0] addr);
        result_t got;
        apb_read(addr, got);
        post_check($sformatf("read 0x%08h", addr), ref_read(addr), got);
    endtask

    task automatic expect_cycles(input int exp);
        if (last_cycles != exp) begin
            errors++;
            $display("Error at %0t ns: access cycles expected %0d, actual %0d",
                     $time, exp, last_cycles);
        end
    endtask

    task automatic check_pins(input logic irq_exp);
        @(negedge clk);
        if (gpio_oe !== sh_dir) begin
            errors++;
            $display("Error at %0t ns: gpio_oe expected 0x%08h, actual 0x%08h",
                     $time, sh_dir, gpio_oe);
        end
        if (gpio_out !== sh_out) begin
            errors++;
            $display("Error at %0t ns: gpio_out expected 0x%08h, actual 0x%08h",
                     $time, sh_out, gpio_out);
        end
        if (timer_irq !== irq_exp) begin
            errors++;
            $display("Error at %0t ns: timer_irq expected %0b, actual %0b",
                     $time, irq_exp, timer_irq);
        end
    endtask

    // compares every completed read against its reference
    always begin
        @(read_done);
        if (chk_got.data !== chk_exp.data) begin
            errors++;
            $display("Error at %0t ns: prdata (%s) expected 0x%08h, actual 0x%08h",
                     $time, chk_name, chk_exp.data, chk_got.data);
        end
        if (chk_got.err !== chk_exp.err) begin
            errors++;
            $display("Error at %0t ns: pslverr (%s) expected %0b, actual %0b",
                     $time, chk_name, chk_exp.err, chk_got.err);
        end
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: transfers did not complete");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        result_t got;
        int      polls;
        int      pick;
        errors     = 0;
        seed       = 13;
        apb_req    = '0;
        gpio_in    = '0;
        rst_n      = 1'b0;
        {sh_dir, sh_out, sh_in, sh_scr0, sh_scr1, sh_cmp, sh_ctrl} = '0;
        offs_tab   = '{`REG_OFFS_0, `REG_OFFS_1, `REG_OFFS_2, `REG_OFFS_3};
        rand_addrs = '{`GPIO_BASE, `GPIO_BASE + 32'h4, `GPIO_BASE + 32'h8,
                       `GPIO_BASE + 32'hC, `SOC_CTRL_BASE + 32'h4, `SOC_CTRL_BASE + 32'h8};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // reset values of every defined register and of the pins
        for (int i = 0; i < 4; i++) begin
            read_check(`GPIO_BASE + {20'b0, offs_tab[i]});
            read_check(`TIMER_BASE + {20'b0, offs_tab[i]});
            read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[i]});
        end
        check_pins(1'b0);

        // GPIO direction, output, toggle and input
        apb_write(`GPIO_BASE + {20'b0, offs_tab[0]}, 32'hFFFF_00F0);
        apb_write(`GPIO_BASE + {20'b0, offs_tab[1]}, 32'h1234_5678);
        read_check(`GPIO_BASE + {20'b0, offs_tab[0]});
        read_check(`GPIO_BASE + {20'b0, offs_tab[1]});
        expect_cycles(1);
        check_pins(1'b0);
        apb_write(`GPIO_BASE + {20'b0, offs_tab[3]}, 32'h0F0F_0001);
        read_check(`GPIO_BASE + {20'b0, offs_tab[1]});
        read_check(`GPIO_BASE + {20'b0, offs_tab[3]});
        check_pins(1'b0);
        @(posedge clk);
        gpio_in <= 32'hCAFE_1234;
        sh_in = 32'hCAFE_1234;
        repeat (4) @(posedge clk);
        read_check(`GPIO_BASE + {20'b0, offs_tab[2]});
        apb_write(`GPIO_BASE + {20'b0, offs_tab[2]}, 32'h5555_5555);

        // SoC control with its one wait state
        read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[0]});
        expect_cycles(2);
        apb_write(`SOC_CTRL_BASE + {20'b0, offs_tab[1]}, 32'hDEAD_BEEF);
        expect_cycles(2);
        apb_write(`SOC_CTRL_BASE + {20'b0, offs_tab[2]}, 32'h0BAD_F00D);
        read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[1]});
        read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[2]});
        apb_write(`SOC_CTRL_BASE + {20'b0, offs_tab[0]}, 32'h1111_2222);
        apb_write(`SOC_CTRL_BASE + {20'b0, offs_tab[3]}, 32'h7);
        read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[0]});
        read_check(`SOC_CTRL_BASE + {20'b0, offs_tab[3]});

        // unmapped addresses and undefined offsets
        read_check(32'h1A10_0000);
        expect_cycles(1);
        read_check(32'h1A10_4000);
        apb_write(32'h1A10_4000, 32'hFFFF_FFFF);
        read_check(`GPIO_BASE + 32'h10);
        read_check(`TIMER_BASE + 32'h20);
        read_check(`SOC_CTRL_BASE + 32'h100);

        // timer with compare 20, enable and clear on match
        apb_write(`TIMER_BASE + {20'b0, offs_tab[2]}, 32'd20);
        apb_write(`TIMER_BASE + {20'b0, offs_tab[0]}, 32'h3);
        read_check(`TIMER_BASE + {20'b0, offs_tab[2]});
        read_check(`TIMER_BASE + {20'b0, offs_tab[0]});
        expect_cycles(1);
        polls = 0;
        got   = '0;
        while (!got.data[0] && polls < MAX_POLLS) begin
            apb_read(`TIMER_BASE + {20'b0, offs_tab[3]}, got);
            polls++;
        end
        if (!got.data[0]) begin
            errors++;
            $display("timer match flag still clear after %0d status polls", polls);
        end
        check_pins(1'b1);
        apb_read(`TIMER_BASE + {20'b0, offs_tab[1]}, got);
        if (got.data > 32'd20) begin
            errors++;
            $display("Error at %0t ns: count expected at most 20, actual %0d", $time, got.data);
        end
        // stop the timer first so that no new match sets the flag again
        apb_write(`TIMER_BASE + {20'b0, offs_tab[0]}, 32'h0);
        apb_write(`TIMER_BASE + {20'b0, offs_tab[3]}, 32'h1);
        check_pins(1'b0);
        read_check(`TIMER_BASE + {20'b0, offs_tab[3]});

        // random reads and writes to GPIO and the scratch registers
        for (int n = 0; n < 200; n++) begin
            pick = int'($unsigned($random(seed)) % 6);
            if ($random(seed) & 1) begin
                apb_write(rand_addrs[pick], $random(seed));
            end else begin
                read_check(rand_addrs[pick]);
            end
        end
        check_pins(1'b0);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
